// File: Bender.yml
package:
  name: tomasulo_core

sources:
  - include_dirs:
      - design
    files:
      - design/tomasulo_pkg.sv
      - design/dispatch_decode.sv
      - design/rs_entry.sv
      - design/issue_select.sv
      - design/alu_execute.sv
      - design/cdb_result.sv
      - design/tomasulo_core.sv
      - target: test
        files:
          - bench/tomasulo_core_tb.sv

// File: bench/tomasulo_core_tb.sv
// Self-checking testbench for the Tomasulo execute cluster with random dependent streams
`include "tomasulo_settings.svh"

module tomasulo_core_tb import tomasulo_pkg::*; ();

    localparam int TAGS    = 1 << `TAG_BITS;
    localparam int PLANNED = 82;                 // Instructions over all tests
    localparam int LIMIT   = 40 * PLANNED + 100; // Watchdog in cycles

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  dispatch_valid;
    op_code                dispatch_op;
    logic [`TAG_BITS-1:0]  dispatch_tag;
    logic [`DATA_BITS-1:0] opa_in;
    logic [`DATA_BITS-1:0] opb_in;
    logic                  opa_valid;
    logic                  opb_valid;
    logic                  dispatch_ready;
    logic                  cdb_valid;
    logic [`TAG_BITS-1:0]  cdb_tag;
    logic [`DATA_BITS-1:0] cdb_value;

    // Own view of every tag
    logic [`DATA_BITS-1:0] expected [TAGS];  // Value of current generation
    bit                    in_flight [TAGS];
    bit                    has_value [TAGS]; // Broadcast at least once
    int                    dep_a [TAGS];     // Producer still owed, 0 if none
    int                    dep_b [TAGS];

    int    errors = 0;
    int    checks = 0;
    int    sent = 0;
    int    outstanding = 0;
    int    stalls = 0;                       // Cycles held by dispatch_ready low
    int    cycles = 0;
    int    tests = 0;
    int    next_tag = 1;
    int    test_errors0;
    int    test_sent0;
    string test_name;

    tomasulo_core UUT (.*);

    always #20 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`DATA_BITS-1:0] alu_model(
        input op_code                op,
        input logic [`DATA_BITS-1:0] a,
        input logic [`DATA_BITS-1:0] b
    );
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            OP_SLL:  return a << b[`SHAMT_BITS-1:0];
            default: return a >> b[`SHAMT_BITS-1:0]; // Logical right
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Result checker
    //////////////////////////////////////////////////////////////////////

    task automatic check_result(
        input logic [`TAG_BITS-1:0]  tag,
        input logic [`DATA_BITS-1:0] value
    );
        checks++;
        if (!in_flight[tag]) begin
            errors++;
            $display("%s: CDB result for tag %0d that was not in flight", test_name, tag);
        end else begin
            if (dep_a[tag] != 0 || dep_b[tag] != 0) begin
                errors++;
                $display("%s: tag %0d finished before its producer", test_name, tag);
            end
            if (value !== expected[tag]) begin
                errors++;
                $display("error %s: tag %0d expected %h actual %h",
                         test_name, tag, expected[tag], value);
            end
            in_flight[tag] = 1'b0;
            has_value[tag] = 1'b1;
            outstanding--;
        end
        for (int t = 1; t < TAGS; t++) begin // Waiters on this tag are now satisfied
            if (dep_a[t] == tag)
                dep_a[t] = 0;
            if (dep_b[t] == tag)
                dep_b[t] = 0;
        end
    endtask

    // CDB flops are sampled before they update
    always @(posedge clock) begin
        if (!reset && cdb_valid)
            check_result(cdb_tag, cdb_value);
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic send(
        input  op_code                op,
        input  bit                    a_val,
        input  logic [`DATA_BITS-1:0] a,
        input  bit                    b_val,
        input  logic [`DATA_BITS-1:0] b,
        output logic [`TAG_BITS-1:0]  tag
    );
        logic [`DATA_BITS-1:0] va;
        logic [`DATA_BITS-1:0] vb;
        while (in_flight[next_tag]) // Reuse only after its result
            @(negedge clock);
        tag = next_tag;
        va  = a_val ? a : expected[a[`TAG_BITS-1:0]]; // Old generation if a names tag
        vb  = b_val ? b : expected[b[`TAG_BITS-1:0]];
        dep_a[tag] = (!a_val && in_flight[a[`TAG_BITS-1:0]]) ? a[`TAG_BITS-1:0] : 0;
        dep_b[tag] = (!b_val && in_flight[b[`TAG_BITS-1:0]]) ? b[`TAG_BITS-1:0] : 0;
        expected[tag]  = alu_model(op, va, vb);
        in_flight[tag] = 1'b1;
        outstanding++;
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_tag   = tag;
        opa_in         = a;
        opa_valid      = a_val;
        opb_in         = b;
        opb_valid      = b_val;
        do begin
            @(posedge clock);
            if (!dispatch_ready)
                stalls++; // Held by back-pressure
        end while (!dispatch_ready);
        @(negedge clock);
        dispatch_valid = 1'b0;
        sent++;
        next_tag = (next_tag == TAGS - 1) ? 1 : next_tag + 1; // Round robin over 1..15
    endtask

    task automatic pick_operand(
        input  int                    mode,   // 1 running tag, 2 finished tag
        output bit                    is_val,
        output logic [`DATA_BITS-1:0] bus
    );
        int cand[$];
        for (int t = 1; t < TAGS; t++) begin
            if ((mode == 1 && in_flight[t]) || (mode == 2 && has_value[t] && !in_flight[t]))
                cand.push_back(t);
        end
        if (cand.size() == 0 || $urandom_range(99, 0) < 25) begin
            is_val = 1'b1;
            bus    = $urandom;
        end else begin
            is_val = 1'b0;
            bus    = cand[$urandom_range(cand.size() - 1, 0)]; // Tag in low bits
        end
    endtask

    task automatic drain();
        while (outstanding != 0)
            @(negedge clock);
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        test_errors0 = errors;
        test_sent0   = sent;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s finished: %0d instructions, %0d errors",
                 test_name, sent - test_sent0, errors - test_errors0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [`TAG_BITS-1:0]  long_tag;
        logic [`TAG_BITS-1:0]  tag;
        logic [`DATA_BITS-1:0] a;
        logic [`DATA_BITS-1:0] b;
        bit                    a_val;
        bit                    b_val;
        int                    stalls0;
        void'($urandom(89));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_ADD;
        dispatch_tag   = '0;
        opa_in         = '0;
        opb_in         = '0;
        opa_valid      = 1'b0;
        opb_valid      = 1'b0;

        begin_test("reset_idle");
        repeat (3) @(negedge clock);
        reset = 1'b0;
        if (dispatch_ready !== 1'b1) begin
            errors++;
            $display("error reset_idle: dispatch_ready expected 1 actual %b", dispatch_ready);
        end
        repeat (8) begin
            @(negedge clock);
            if (cdb_valid !== 1'b0) begin
                errors++;
                $display("reset_idle: CDB pulse seen with nothing dispatched");
            end
        end
        end_test();

        begin_test("independent"); // Every opcode twice, value operands
        repeat (2) begin
            for (int op = 0; op < 8; op++)
                send(op_code'(op), 1'b1, $urandom, 1'b1, $urandom, tag);
        end
        drain();
        end_test();

        begin_test("dependent_chain"); // Operands name running producers
        repeat (40) begin
            pick_operand(1, a_val, a);
            pick_operand(1, b_val, b);
            send(op_code'($urandom_range(7, 0)), a_val, a, b_val, b, tag);
        end
        drain();
        end_test();

        begin_test("late_dependent"); // Operands name finished tags
        repeat (20) begin
            pick_operand(2, a_val, a);
            pick_operand(2, b_val, b);
            send(op_code'($urandom_range(7, 0)), a_val, a, b_val, b, tag);
        end
        drain();
        end_test();

        begin_test("back_pressure");
        send(OP_SLL, 1'b1, $urandom, 1'b1, $urandom | 32'h1f, long_tag); // 31-bit shift
        stalls0 = stalls;
        repeat (`RS_ENTRIES + 1) // One more than the station holds
            send(op_code'($urandom_range(7, 0)), 1'b0, long_tag, 1'b1, $urandom, tag);
        if (stalls == stalls0) begin
            errors++;
            $display("back_pressure: dispatch_ready never went low with every entry waiting");
        end
        drain();
        end_test();

        $display("tests %0d, instructions %0d, results checked %0d, errors %0d",
                 tests, sent, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial begin
        while (cycles < LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d results missing", cycles, outstanding);
        for (int t = 1; t < TAGS; t++) begin
            if (in_flight[t])
                $display("tag %0d never appeared on the CDB", t);
        end
        $display("Errors found");
        $finish;
    end

endmodule

// File: design/alu_execute.sv
// Execute stage with single-cycle logic ops and bit-serial shifts
`include "tomasulo_settings.svh"

module alu_execute import tomasulo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  logic [`DATA_BITS-1:0] issue_opa,
    input  logic [`DATA_BITS-1:0] issue_opb,
    input  logic [`TAG_BITS-1:0]  issue_tag,
    input  alu_func               issue_func,
    output logic                  alu_busy,
    output logic                  done,
    output logic [`TAG_BITS-1:0]  done_tag,
    output logic [`DATA_BITS-1:0] done_value
);

    alu_state               state, state_next;
    logic [`DATA_BITS-1:0]  work;        // Result, or shift operand in flight
    logic [`SHAMT_BITS-1:0] count;       // Shift steps left
    logic                   shift_left;
    logic [`TAG_BITS-1:0]   tag_q;
    logic                   is_shift;
    logic [`DATA_BITS-1:0]  quick_result;

    // Zero-amount shifts finish like a logic op
    assign is_shift   = issue_func inside {ALU_SLL, ALU_SRL} &&
                        issue_opb[`SHAMT_BITS-1:0] != '0;
    assign alu_busy   = state == ALU_SHIFT;
    assign done       = state == ALU_DONE;
    assign done_tag   = tag_q;
    assign done_value = work;

    // Single-cycle functions
    always_comb begin
        case (issue_func)
            ALU_ADD: quick_result = issue_opa + issue_opb;
            ALU_SUB: quick_result = issue_opa - issue_opb;
            ALU_AND: quick_result = issue_opa & issue_opb;
            ALU_OR:  quick_result = issue_opa | issue_opb;
            ALU_XOR: quick_result = issue_opa ^ issue_opb;
            ALU_SLT: quick_result = {{(`DATA_BITS - 1){1'b0}},
                                     $signed(issue_opa) < $signed(issue_opb)};
            default: quick_result = issue_opa; // Shifts start from opa
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ALU_SHIFT: if (count == 1) state_next = ALU_DONE; // Last step on this edge
            default: begin // Idle and done both accept an issue
                if (issue_valid)
                    state_next = is_shift ? ALU_SHIFT : ALU_DONE;
                else
                    state_next = ALU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= ALU_IDLE;
        else
            state <= state_next;
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            work       <= quick_result;
            count      <= issue_opb[`SHAMT_BITS-1:0];
            shift_left <= issue_func == ALU_SLL;
            tag_q      <= issue_tag;
        end else if (alu_busy) begin
            work  <= shift_left ? work << 1 : work >> 1; // One bit per cycle
            count <= count - 1'b1;
        end
    end

    // Issue select must hold off while a shift runs
    a_no_issue_busy: assert property (
        @(posedge clock) disable iff (reset) alu_busy |-> !issue_valid
    ) else $error("issue while ALU busy");

endmodule

// File: design/cdb_result.sv
// Result stage that drives the CDB and keeps per-tag done bits and values
`include "tomasulo_settings.svh"

module cdb_result (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  done,
    input  logic [`TAG_BITS-1:0]  done_tag,
    input  logic [`DATA_BITS-1:0] done_value,
    input  logic                  dispatch_accept,
    input  logic [`TAG_BITS-1:0]  dispatch_tag,
    input  logic [`TAG_BITS-1:0]  opa_lookup_tag,
    input  logic [`TAG_BITS-1:0]  opb_lookup_tag,
    output logic                  cdb_valid,
    output logic [`TAG_BITS-1:0]  cdb_tag,
    output logic [`DATA_BITS-1:0] cdb_value,
    output logic                  opa_done,
    output logic                  opb_done,
    output logic [`DATA_BITS-1:0] opa_done_value,
    output logic [`DATA_BITS-1:0] opb_done_value
);

    localparam int TAGS = 2 ** `TAG_BITS;

    logic [TAGS-1:0]       tag_done;          // Result seen since last dispatch
    logic [`DATA_BITS-1:0] tag_value [TAGS];  // Last broadcast value per tag

    // CDB register stage
    always_ff @(posedge clock) begin
        if (reset)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= done;
        cdb_tag   <= done_tag;
        cdb_value <= done_value;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tag_done <= '0;
        end else begin
            if (cdb_valid)
                tag_done[cdb_tag] <= 1'b1;
            if (dispatch_accept)
                tag_done[dispatch_tag] <= 1'b0; // Reused tag goes stale
        end
    end

    always_ff @(posedge clock) begin
        if (cdb_valid)
            tag_value[cdb_tag] <= cdb_value;
    end

    // Lookup ports for dispatch
    assign opa_done       = tag_done[opa_lookup_tag];
    assign opb_done       = tag_done[opb_lookup_tag];
    assign opa_done_value = tag_value[opa_lookup_tag];
    assign opb_done_value = tag_value[opb_lookup_tag];

    // Every broadcast traces back to a nonzero dispatch tag
    a_tag_nonzero: assert property (
        @(posedge clock) disable iff (reset) cdb_valid |-> cdb_tag != '0
    ) else $error("CDB broadcast with tag 0");

endmodule

// File: design/dispatch_decode.sv
// Dispatch decode stage that resolves operands and picks a free entry
`include "tomasulo_settings.svh"

module dispatch_decode import tomasulo_pkg::*; (
    input  logic                   dispatch_valid,
    input  op_code                 dispatch_op,
    input  logic [`TAG_BITS-1:0]   dispatch_tag,
    input  logic [`DATA_BITS-1:0]  opa_in,
    input  logic [`DATA_BITS-1:0]  opb_in,
    input  logic                   opa_valid,
    input  logic                   opb_valid,
    input  logic [`RS_ENTRIES-1:0] entry_avail,
    input  logic                   cdb_valid,
    input  logic [`TAG_BITS-1:0]   cdb_tag,
    input  logic [`DATA_BITS-1:0]  cdb_value,
    input  logic                   opa_done,
    input  logic                   opb_done,
    input  logic [`DATA_BITS-1:0]  opa_done_value,
    input  logic [`DATA_BITS-1:0]  opb_done_value,
    output logic [`TAG_BITS-1:0]   opa_lookup_tag,
    output logic [`TAG_BITS-1:0]   opb_lookup_tag,
    output logic                   dispatch_ready,
    output logic [`RS_ENTRIES-1:0] entry_load,
    output alu_func                dec_func,
    output logic [`DATA_BITS-1:0]  dec_opa,
    output logic [`DATA_BITS-1:0]  dec_opb,
    output logic                   dec_opa_valid,
    output logic                   dec_opb_valid,
    output logic [`TAG_BITS-1:0]   dec_opa_tag,
    output logic [`TAG_BITS-1:0]   dec_opb_tag,
    output logic [`TAG_BITS-1:0]   dec_dest_tag
);

    // Returns {valid, value}; bypass beats table, table beats waiting
    function automatic logic [`DATA_BITS:0] resolve(
        input logic [`DATA_BITS-1:0] op,
        input logic                  op_valid,
        input logic                  done,
        input logic [`DATA_BITS-1:0] done_value
    );
        if (op_valid)
            return {1'b1, op};
        if (cdb_valid && cdb_tag == op[`TAG_BITS-1:0])
            return {1'b1, cdb_value}; // Producer broadcasting right now
        if (done)
            return {1'b1, done_value}; // Producer finished earlier
        return {1'b0, op}; // Still waiting on the tag
    endfunction

    assign opa_lookup_tag = opa_in[`TAG_BITS-1:0];
    assign opb_lookup_tag = opb_in[`TAG_BITS-1:0];
    assign dispatch_ready = |entry_avail; // Any slot free
    assign dec_dest_tag   = dispatch_tag;

    always_comb begin
        {dec_opa_valid, dec_opa} = resolve(opa_in, opa_valid, opa_done, opa_done_value);
        {dec_opb_valid, dec_opb} = resolve(opb_in, opb_valid, opb_done, opb_done_value);
        dec_opa_tag = dec_opa_valid ? '0 : opa_lookup_tag; // Tag kept only if waiting
        dec_opb_tag = dec_opb_valid ? '0 : opb_lookup_tag;

        case (dispatch_op)
            OP_ADD:  dec_func = ALU_ADD;
            OP_SUB:  dec_func = ALU_SUB;
            OP_AND:  dec_func = ALU_AND;
            OP_OR:   dec_func = ALU_OR;
            OP_XOR:  dec_func = ALU_XOR;
            OP_SLT:  dec_func = ALU_SLT;
            OP_SLL:  dec_func = ALU_SLL;
            default: dec_func = ALU_SRL;
        endcase

        // Downward scan so the lowest free entry wins
        entry_load = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (entry_avail[i]) begin
                entry_load    = '0;
                entry_load[i] = dispatch_valid;
            end
        end

        // Tag 0 marks a free entry, so it can never name a destination
        assert final (!dispatch_valid || dispatch_tag != '0)
            else $error("dispatch with destination tag 0");
    end

endmodule

// File: design/issue_select.sv
// Issue select that grants the lowest ready entry to the ALU
`include "tomasulo_settings.svh"

module issue_select import tomasulo_pkg::*; (
    input  logic [`RS_ENTRIES-1:0] entry_ready,
    input  logic [`DATA_BITS-1:0]  entry_opa [`RS_ENTRIES],
    input  logic [`DATA_BITS-1:0]  entry_opb [`RS_ENTRIES],
    input  alu_func                entry_func [`RS_ENTRIES],
    input  logic [`TAG_BITS-1:0]   entry_tag [`RS_ENTRIES],
    input  logic                   alu_busy,
    output logic [`RS_ENTRIES-1:0] entry_free,
    output logic                   issue_valid,
    output logic [`DATA_BITS-1:0]  issue_opa,
    output logic [`DATA_BITS-1:0]  issue_opb,
    output alu_func                issue_func,
    output logic [`TAG_BITS-1:0]   issue_tag
);

    always_comb begin
        // Fixed priority with the lowest index scanned last so it wins
        entry_free = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                entry_free    = '0;
                entry_free[i] = !alu_busy; // Hold all while ALU shifts
            end
        end
        issue_valid = |entry_free;

        // One-hot mux of the granted entry
        issue_opa  = '0;
        issue_opb  = '0;
        issue_func = ALU_ADD;
        issue_tag  = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (entry_free[i]) begin
                issue_opa  = entry_opa[i];
                issue_opb  = entry_opb[i];
                issue_func = entry_func[i];
                issue_tag  = entry_tag[i];
            end
        end

        // A ready entry always holds a live destination tag
        assert final (!issue_valid || issue_tag != '0)
            else $error("issue of an entry with no destination tag");
    end

endmodule

// File: design/rs_entry.sv
// Reservation-station entry that waits on CDB tags until both operands are ready
`include "tomasulo_settings.svh"

module rs_entry import tomasulo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  load,
    input  alu_func               dec_func,
    input  logic [`DATA_BITS-1:0] dec_opa,
    input  logic [`DATA_BITS-1:0] dec_opb,
    input  logic                  dec_opa_valid,
    input  logic                  dec_opb_valid,
    input  logic [`TAG_BITS-1:0]  dec_opa_tag,
    input  logic [`TAG_BITS-1:0]  dec_opb_tag,
    input  logic [`TAG_BITS-1:0]  dec_dest_tag,
    input  logic                  free,
    input  logic                  cdb_valid,
    input  logic [`TAG_BITS-1:0]  cdb_tag,
    input  logic [`DATA_BITS-1:0] cdb_value,
    output logic                  ready,
    output logic                  avail,
    output logic [`DATA_BITS-1:0] opa_out,
    output logic [`DATA_BITS-1:0] opb_out,
    output alu_func               func_out,
    output logic [`TAG_BITS-1:0]  tag_out
);

    logic [`DATA_BITS-1:0] opa_q, opb_q;       // Operand values
    logic [`TAG_BITS-1:0]  opa_tag, opb_tag;   // Producer tags while waiting
    logic [`TAG_BITS-1:0]  dest_tag;           // Nonzero while occupied
    logic                  opa_ok, opb_ok;     // Operand holds a value
    alu_func               func_q;
    logic                  in_use;
    logic                  grab_a, grab_b;

    assign in_use   = dest_tag != '0;
    assign avail    = !in_use;
    assign ready    = in_use && opa_ok && opb_ok; // ALU busy gate is in issue_select
    assign opa_out  = opa_q;
    assign opb_out  = opb_q;
    assign func_out = func_q;
    assign tag_out  = dest_tag;

    // Snoop the CDB for our producers
    assign grab_a = in_use && !opa_ok && cdb_valid && cdb_tag == opa_tag;
    assign grab_b = in_use && !opb_ok && cdb_valid && cdb_tag == opb_tag;

    always_ff @(posedge clock) begin
        if (reset || (free && !load)) begin
            opa_q    <= '0;
            opb_q    <= '0;
            opa_tag  <= '0;
            opb_tag  <= '0;
            dest_tag <= '0;
            opa_ok   <= 1'b0;
            opb_ok   <= 1'b0;
            func_q   <= ALU_ADD;
        end else if (load && !in_use) begin
            opa_q    <= dec_opa;
            opb_q    <= dec_opb;
            opa_tag  <= dec_opa_tag;
            opb_tag  <= dec_opb_tag;
            dest_tag <= dec_dest_tag;
            opa_ok   <= dec_opa_valid;
            opb_ok   <= dec_opb_valid;
            func_q   <= dec_func;
        end else begin
            if (grab_a) begin
                opa_q  <= cdb_value;
                opa_ok <= 1'b1;
            end
            if (grab_b) begin
                opb_q  <= cdb_value;
                opb_ok <= 1'b1;
            end
        end
    end

    // Decode loads only free slots and issue frees only busy ones
    a_no_load_and_free: assert property (
        @(posedge clock) disable iff (reset) !(load && free)
    ) else $error("entry loaded and freed in the same cycle");

endmodule

// File: design/tomasulo_core.sv
// Out-of-order execute cluster with reservation station, ALU and CDB
`include "tomasulo_settings.svh"

module tomasulo_core import tomasulo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  op_code                dispatch_op,
    input  logic [`TAG_BITS-1:0]  dispatch_tag,
    input  logic [`DATA_BITS-1:0] opa_in,
    input  logic [`DATA_BITS-1:0] opb_in,
    input  logic                  opa_valid,
    input  logic                  opb_valid,
    output logic                  dispatch_ready,
    output logic                  cdb_valid,
    output logic [`TAG_BITS-1:0]  cdb_tag,
    output logic [`DATA_BITS-1:0] cdb_value
);

    //////////////////////////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////////////////////////

    logic [`TAG_BITS-1:0]   opa_lookup_tag, opb_lookup_tag;
    logic                   opa_done, opb_done;
    logic [`DATA_BITS-1:0]  opa_done_value, opb_done_value;
    logic [`RS_ENTRIES-1:0] entry_load, entry_free, entry_ready, entry_avail;
    alu_func                dec_func;
    logic [`DATA_BITS-1:0]  dec_opa, dec_opb;
    logic                   dec_opa_valid, dec_opb_valid;
    logic [`TAG_BITS-1:0]   dec_opa_tag, dec_opb_tag, dec_dest_tag;
    logic [`DATA_BITS-1:0]  entry_opa [`RS_ENTRIES];
    logic [`DATA_BITS-1:0]  entry_opb [`RS_ENTRIES];
    alu_func                entry_func [`RS_ENTRIES];
    logic [`TAG_BITS-1:0]   entry_tag [`RS_ENTRIES];
    logic                   issue_valid, alu_busy, done;
    logic [`DATA_BITS-1:0]  issue_opa, issue_opb, done_value;
    alu_func                issue_func;
    logic [`TAG_BITS-1:0]   issue_tag, done_tag;
    logic                   dispatch_accept;

    assign dispatch_accept = dispatch_valid && dispatch_ready;

    dispatch_decode u_decode (.*);

    for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_rs
        rs_entry u_entry (
            .clock, .reset,
            .load(entry_load[i]),
            .dec_func, .dec_opa, .dec_opb, .dec_opa_valid, .dec_opb_valid,
            .dec_opa_tag, .dec_opb_tag, .dec_dest_tag,
            .free(entry_free[i]),
            .cdb_valid, .cdb_tag, .cdb_value,
            .ready(entry_ready[i]),
            .avail(entry_avail[i]),
            .opa_out(entry_opa[i]),
            .opb_out(entry_opb[i]),
            .func_out(entry_func[i]),
            .tag_out(entry_tag[i])
        );
    end

    issue_select u_select (.*);

    alu_execute u_alu (.*);

    cdb_result u_cdb (.*);

endmodule

// File: design/tomasulo_pkg.sv
// Shared opcode, ALU function and ALU state types for the execute cluster
package tomasulo_pkg;

    // Dispatch opcode as seen on the external port
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL
    } op_code;

    // Function held in an entry and run by the ALU
    typedef enum logic [2:0] {
        ALU_ADD, // Reset value of an entry
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_func;

    // ALU control FSM
    typedef enum logic [1:0] {
        ALU_IDLE,
        ALU_SHIFT, // Bit-serial shift in progress
        ALU_DONE   // Result valid toward CDB stage
    } alu_state;

endpackage

// File: design/tomasulo_settings.svh
// Tomasulo execute cluster widths and reservation-station size
`ifndef TOMASULO_SETTINGS_SVH
`define TOMASULO_SETTINGS_SVH

// ROB tag width, tag 0 means no tag
`define TAG_BITS 4

// Reservation-station entries, 2 to 8
`define RS_ENTRIES 4

// Operand and result width
`define DATA_BITS 32

// Shift amount taken from low bits of operand B
`define SHAMT_BITS 5

`endif

// File: filelist.f
+incdir+design
design/tomasulo_pkg.sv
design/dispatch_decode.sv
design/rs_entry.sv
design/issue_select.sv
design/alu_execute.sv
design/cdb_result.sv
design/tomasulo_core.sv
bench/tomasulo_core_tb.sv
